/* build.f */
+incdir+.
xb_pkg.sv
xb_route_table.sv
xb_ingress_buffer.sv
xb_egress_arbiter.sv
xb_crossbar.sv
tb_crossbar.sv

/* tb_crossbar.sv */
`timescale 1ns/1ns
`default_nettype none

`include "xb_macros.svh"

module tb_crossbar
  import xb_pkg::*;
();

  localparam int NP         = `XB_NPORTS;
  localparam int TBL_DEPTH  = 1 << `XB_TBL_LOG2;
  localparam int MAX_STEPS  = 64;
  localparam int WAIT_LIMIT = 5000;
  localparam bit K_CFG      = 1'b0;
  localparam bit K_PKT      = 1'b1;

  logic                   clk;
  logic                   reset;
  xb_word_t [NP-1:0]      in_data;
  xb_port_mask_t          in_last;
  xb_port_mask_t          in_valid;
  wire xb_port_mask_t     in_ready;
  wire xb_word_t [NP-1:0] out_data;
  wire xb_port_mask_t     out_last;
  wire xb_port_mask_t     out_valid;
  xb_port_mask_t          out_ready;
  logic                   cfg_stb;
  xb_epid_t               cfg_epid;
  xb_port_t               cfg_port;
  wire                    cfg_ack;

  // Stimulus table where a packet step uses st_port as its source port
  bit       st_kind [MAX_STEPS];
  int       st_grp  [MAX_STEPS];
  xb_epid_t st_epid [MAX_STEPS];
  int       st_port [MAX_STEPS];
  int       st_len  [MAX_STEPS];
  bit       st_fair [MAX_STEPS];
  int       n_steps;

  // Reference routing table with oldest-first replacement
  xb_epid_t m_epid  [TBL_DEPTH];
  xb_port_t m_port  [TBL_DEPTH];
  bit       m_valid [TBL_DEPTH];
  int       m_ptr;

  // Scoreboards of expected packets per source and egress, and the send queues
  int exp_q   [NP][NP][$];
  int send_q  [NP][$];
  int order_q [NP][$];
  int sent_cnt [NP];
  int recv_cnt [NP];
  int mon_pkt  [NP];
  int mon_idx  [NP];
  int cur_grp;
  int fair_cnt;
  int fair_egress;
  bit stb_seen;

  xb_crossbar DUT (
    .clk         (clk),
    .reset       (reset),
    .i_in_data   (in_data),
    .i_in_last   (in_last),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .o_out_data  (out_data),
    .o_out_last  (out_last),
    .o_out_valid (out_valid),
    .i_out_ready (out_ready),
    .i_cfg_stb   (cfg_stb),
    .i_cfg_epid  (cfg_epid),
    .i_cfg_port  (cfg_port),
    .o_cfg_ack   (cfg_ack)
  );

  // ----------------------------------------------------------------------
  // Failure reporting and the compare task
  // ----------------------------------------------------------------------

  task automatic end_in_failure();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end_in_failure();
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model and word format
  // ----------------------------------------------------------------------

  // Header carries the ID in bits 15..0 and payload words carry the word index
  function automatic xb_word_t make_word(input int src, input int seq, input int idx,
                                         input xb_epid_t epid);
    if (idx == 0) begin
      make_word = {8'hC0, 8'(src), 16'(seq), 16'h0000, epid};
    end else begin
      make_word = {8'hD0, 8'(src), 16'(seq), 16'(idx), 16'h0000};
    end
  endfunction

  // A known ID keeps its entry while a new one overwrites the oldest
  function automatic void model_write(input xb_epid_t epid, input xb_port_t port);
    int hit;
    hit = -1;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      if (m_valid[i] && (m_epid[i] == epid)) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      hit   = m_ptr;
      m_ptr = (m_ptr + 1) % TBL_DEPTH;
    end
    m_valid[hit] = 1'b1;
    m_epid[hit]  = epid;
    m_port[hit]  = port;
  endfunction

  function automatic int model_route(input xb_epid_t epid);
    model_route = `XB_DEFAULT_PORT;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      if (m_valid[i] && (m_epid[i] == epid)) begin
        model_route = m_port[i];
      end
    end
  endfunction

  function automatic void add_step(input bit kind, input int grp, input xb_epid_t epid,
                                   input int port, input int len, input bit fair);
    st_kind[n_steps] = kind;
    st_grp[n_steps]  = grp;
    st_epid[n_steps] = epid;
    st_port[n_steps] = port;
    st_len[n_steps]  = len;
    st_fair[n_steps] = fair;
    n_steps++;
  endfunction

  function automatic void queue_packet(input int p);
    int src;
    int egr;
    src = st_port[p];
    egr = model_route(st_epid[p]);
    exp_q[src][egr].push_back(p);
    send_q[src].push_back(p);
    sent_cnt[src]++;
    if (st_fair[p]) begin
      fair_cnt++;
      fair_egress = egr;
    end
  endfunction

  // ----------------------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------------------

  task automatic write_cfg(input xb_epid_t epid, input xb_port_t port);
    int t;
    cfg_epid = epid;
    cfg_port = port;
    cfg_stb  = 1'b1;
    @(negedge clk);
    cfg_stb = 1'b0;
    t = 0;
    while (cfg_ack !== 1'b1) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) begin
        $display("Configuration write of ID %h was never acknowledged", epid);
        end_in_failure();
      end
    end
    model_write(epid, port);
  endtask

  // One word per handshake and valid stays high until the source queue is empty
  task automatic send_packets(input int s);
    int p;
    int t;
    while (send_q[s].size() > 0) begin
      p = send_q[s].pop_front();
      for (int w = 0; w < st_len[p]; w++) begin
        in_data[s]  = make_word(s, p, w, st_epid[p]);
        in_last[s]  = (w == st_len[p] - 1);
        in_valid[s] = 1'b1;
        t = 0;
        while (in_ready[s] !== 1'b1) begin
          @(negedge clk);
          t++;
          if (t > WAIT_LIMIT) begin
            $display("Ingress %0d stayed not ready for packet %0d", s, p);
            end_in_failure();
          end
        end
        @(negedge clk);
        in_valid[s] = 1'b0;
      end
    end
  endtask

  task automatic wait_drained();
    int t;
    bit busy;
    t = 0;
    do begin
      busy = 1'b0;
      for (int m = 0; m < NP; m++) begin
        busy |= (mon_pkt[m] >= 0);
        for (int s = 0; s < NP; s++) begin
          busy |= (exp_q[s][m].size() != 0);
        end
      end
      if (busy) begin
        @(negedge clk);
        t++;
        if (t > WAIT_LIMIT) begin
          $display("Expected packets did not come out of the crossbar in time");
          end_in_failure();
        end
      end
    end while (busy);
  endtask

  // Within every group of NP packets each source appears exactly once
  task automatic check_rounds(input int m);
    xb_port_mask_t seen;
    seen = '0;
    for (int i = 0; i < order_q[m].size(); i++) begin
      if (i % NP == 0) begin
        seen = '0;
      end
      if (seen[order_q[m][i]]) begin
        $display("Source %0d was served twice in one round on egress %0d", order_q[m][i], m);
        end_in_failure();
      end
      seen[order_q[m][i]] = 1'b1;
    end
  endtask

  // All four sources start together and then the crossbar drains
  task automatic finish_batch();
    for (int m = 0; m < NP; m++) begin
      order_q[m].delete();
    end
    for (int s = 0; s < NP; s++) begin
      automatic int src = s;
      fork
        send_packets(src);
      join_none
    end
    wait fork;
    wait_drained();
    // Empty buffers accept words again on every ingress
    compare_value(in_ready, {NP{1'b1}}, "ingress ready after the crossbar drained");
    if (fair_cnt > 0) begin
      check_rounds(fair_egress);
    end
    fair_cnt = 0;
    cur_grp  = -1;
  endtask

  // ----------------------------------------------------------------------
  // Monitors that sample on the rising edge
  // ----------------------------------------------------------------------

  task automatic take_word(input int m);
    int src;
    int p;
    if (mon_pkt[m] < 0) begin
      src = int'(out_data[m][49:48]);
      if (exp_q[src][m].size() == 0) begin
        $display("Unexpected packet from source %0d on egress %0d at %0t ns", src, m, $time);
        end_in_failure();
      end else begin
        mon_pkt[m] = exp_q[src][m].pop_front();
        mon_idx[m] = 0;
      end
    end
    p = mon_pkt[m];
    compare_value(out_data[m], make_word(st_port[p], p, mon_idx[m], st_epid[p]),
                  $sformatf("egress %0d packet %0d word %0d", m, p, mon_idx[m]));
    compare_value(out_last[m], (mon_idx[m] == st_len[p] - 1),
                  $sformatf("egress %0d packet %0d last flag", m, p));
    mon_idx[m]++;
    if (out_last[m]) begin
      order_q[m].push_back(st_port[p]);
      recv_cnt[st_port[p]]++;
      mon_pkt[m] = -1;
    end
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      for (int m = 0; m < NP; m++) begin
        if ((out_valid[m] === 1'b1) && (out_ready[m] === 1'b1)) begin
          take_word(m);
        end
      end
    end
  end

  // Acknowledge must follow each strobe by exactly one cycle
  always @(posedge clk) begin
    if (!reset) begin
      compare_value(cfg_ack, stb_seen, "configuration acknowledge");
    end
    stb_seen = reset ? 1'b0 : cfg_stb;
  end

  // ----------------------------------------------------------------------
  // Clock, random output ready and watchdog
  // ----------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    void'($urandom(32'h7468));
    out_ready = '0;
    @(posedge clk);
    forever begin
      @(negedge clk);
      for (int m = 0; m < NP; m++) begin
        out_ready[m] = (($urandom % 4) != 0);
      end
    end
  end

  initial begin
    repeat (200000) @(posedge clk);
    $display("Simulation did not finish within the cycle limit");
    end_in_failure();
  end

  // ----------------------------------------------------------------------
  // Stimulus table and main sequence
  // ----------------------------------------------------------------------

  task automatic build_table();
    n_steps = 0;
    // Three routes and then mixed traffic with one unknown ID
    add_step(K_CFG, 0, 16'h1001, 1, 0, 0);
    add_step(K_CFG, 0, 16'h1002, 2, 0, 0);
    add_step(K_CFG, 0, 16'h1003, 3, 0, 0);
    add_step(K_PKT, 1, 16'h1001, 0, 4, 0);
    add_step(K_PKT, 1, 16'h1002, 1, 1, 0);
    add_step(K_PKT, 1, 16'h1003, 2, 32, 0);
    add_step(K_PKT, 1, 16'h7777, 3, 5, 0);
    add_step(K_PKT, 1, 16'h1002, 0, 3, 0);
    add_step(K_PKT, 1, 16'h1001, 1, 7, 0);
    add_step(K_PKT, 1, 16'h1001, 2, 2, 0);
    add_step(K_PKT, 1, 16'h1003, 3, 6, 0);
    add_step(K_PKT, 1, 16'h1001, 0, 9, 0);
    // Rewriting 1002 moves its traffic from egress 2 to egress 3
    add_step(K_CFG, 0, 16'h1002, 3, 0, 0);
    add_step(K_PKT, 2, 16'h1002, 0, 5, 0);
    add_step(K_PKT, 2, 16'h1002, 1, 2, 0);
    add_step(K_PKT, 2, 16'h1002, 0, 1, 0);
    // Two rounds of all sources competing for egress 2
    add_step(K_CFG, 0, 16'h2000, 2, 0, 0);
    for (int r = 0; r < 2 * NP; r++) begin
      add_step(K_PKT, 3, 16'h2000, r % NP, 8, 1);
    end
    // Ninth distinct ID evicts 1001 as the oldest entry
    add_step(K_CFG, 0, 16'h3001, 1, 0, 0);
    add_step(K_CFG, 0, 16'h3002, 2, 0, 0);
    add_step(K_CFG, 0, 16'h3003, 3, 0, 0);
    add_step(K_CFG, 0, 16'h3004, 0, 0, 0);
    add_step(K_CFG, 0, 16'h3005, 1, 0, 0);
    add_step(K_PKT, 4, 16'h1001, 0, 3, 0);
    add_step(K_PKT, 4, 16'h3005, 1, 4, 0);
    add_step(K_PKT, 4, 16'h1002, 2, 6, 0);
    add_step(K_PKT, 4, 16'h3001, 3, 2, 0);
    // Heavier mix under random output ready
    add_step(K_PKT, 5, 16'h3002, 0, 12, 0);
    add_step(K_PKT, 5, 16'h3002, 1, 3, 0);
    add_step(K_PKT, 5, 16'h3004, 2, 1, 0);
    add_step(K_PKT, 5, 16'h0055, 3, 16, 0);
    add_step(K_PKT, 5, 16'h3002, 0, 2, 0);
    add_step(K_PKT, 5, 16'h1003, 1, 20, 0);
    add_step(K_PKT, 5, 16'h3004, 2, 31, 0);
    add_step(K_PKT, 5, 16'h3001, 3, 1, 0);
  endtask

  initial begin
    reset    = 1'b1;
    in_data  = '0;
    in_last  = '0;
    in_valid = '0;
    cfg_stb  = 1'b0;
    cfg_epid = '0;
    cfg_port = '0;
    stb_seen = 1'b0;
    m_ptr    = 0;
    cur_grp  = -1;
    fair_cnt = 0;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      m_valid[i] = 1'b0;
    end
    for (int n = 0; n < NP; n++) begin
      sent_cnt[n] = 0;
      recv_cnt[n] = 0;
      mon_pkt[n]  = -1;
      mon_idx[n]  = 0;
    end
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Packets of one group run together and a config step closes the group
    for (int i = 0; i < n_steps; i++) begin
      if ((cur_grp >= 0) && ((st_kind[i] == K_CFG) || (st_grp[i] != cur_grp))) begin
        finish_batch();
      end
      if (st_kind[i] == K_CFG) begin
        write_cfg(st_epid[i], xb_port_t'(st_port[i]));
      end else begin
        queue_packet(i);
        cur_grp = st_grp[i];
      end
    end
    if (cur_grp >= 0) begin
      finish_batch();
    end

    for (int s = 0; s < NP; s++) begin
      compare_value(recv_cnt[s], sent_cnt[s], $sformatf("packet count of source %0d", s));
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* xb_crossbar.sv */
`timescale 1ns/1ns
`default_nettype none

`include "xb_macros.svh"

module xb_crossbar
  import xb_pkg::*;
(
  input  wire                            clk,
  input  wire                            reset,
  // Ingress streams
  input  wire xb_word_t [`XB_NPORTS-1:0] i_in_data,
  input  wire xb_port_mask_t             i_in_last,
  input  wire xb_port_mask_t             i_in_valid,
  output wire xb_port_mask_t             o_in_ready,
  // Egress streams
  output wire xb_word_t [`XB_NPORTS-1:0] o_out_data,
  output wire xb_port_mask_t             o_out_last,
  output wire xb_port_mask_t             o_out_valid,
  input  wire xb_port_mask_t             i_out_ready,
  // Routing table configuration
  input  wire                            i_cfg_stb,
  input  wire xb_epid_t                  i_cfg_epid,
  input  wire xb_port_t                  i_cfg_port,
  output wire                            o_cfg_ack
);

  // Lookup path between the ingresses and the shared table
  wire xb_port_mask_t             lookup_req;
  wire xb_epid_t [`XB_NPORTS-1:0] lookup_epid;
  wire xb_port_mask_t             result_valid;
  wire xb_port_mask_t             result_hit;
  wire xb_port_t                  result_port;

  // Heads of all ingress buffers, seen by every egress
  wire xb_port_mask_t             head_valid;
  wire xb_port_mask_t             head_last;
  wire xb_word_t [`XB_NPORTS-1:0] head_data;
  wire xb_port_t [`XB_NPORTS-1:0] head_port;

  // Take masks indexed by egress, and the same bits regrouped by ingress
  wire xb_port_mask_t             take_by_egress  [`XB_NPORTS];
  wire xb_port_mask_t             take_by_ingress [`XB_NPORTS];

  // ----------------------------------------------------------------------
  // Routing table
  // ----------------------------------------------------------------------

  xb_route_table u_route_table (
    .clk            (clk),
    .reset          (reset),
    .i_cfg_stb      (i_cfg_stb),
    .i_cfg_epid     (i_cfg_epid),
    .i_cfg_port     (i_cfg_port),
    .o_cfg_ack      (o_cfg_ack),
    .i_lookup_req   (lookup_req),
    .i_lookup_epid  (lookup_epid),
    .o_result_valid (result_valid),
    .o_result_hit   (result_hit),
    .o_result_port  (result_port)
  );

  // ----------------------------------------------------------------------
  // Ingress buffers, egress arbiters and the take transpose
  // ----------------------------------------------------------------------

  for (genvar n = 0; n < `XB_NPORTS; n++) begin : g_ingress
    xb_ingress_buffer u_ingress (
      .clk            (clk),
      .reset          (reset),
      .i_in_data      (i_in_data[n]),
      .i_in_last      (i_in_last[n]),
      .i_in_valid     (i_in_valid[n]),
      .o_in_ready     (o_in_ready[n]),
      .o_lookup_req   (lookup_req[n]),
      .o_lookup_epid  (lookup_epid[n]),
      .i_result_valid (result_valid[n]),
      .i_result_hit   (result_hit[n]),
      .i_result_port  (result_port),
      .o_head_data    (head_data[n]),
      .o_head_last    (head_last[n]),
      .o_head_valid   (head_valid[n]),
      .o_head_port    (head_port[n]),
      .i_egress_take  (take_by_ingress[n])
    );

    // Bit m of this mask says egress m takes from ingress n
    for (genvar m = 0; m < `XB_NPORTS; m++) begin : g_take
      assign take_by_ingress[n][m] = take_by_egress[m][n];
    end
  end

  for (genvar m = 0; m < `XB_NPORTS; m++) begin : g_egress
    xb_egress_arbiter #(
      .PORT_INDEX (m)
    ) u_egress (
      .clk          (clk),
      .reset        (reset),
      .i_head_valid (head_valid),
      .i_head_last  (head_last),
      .i_head_data  (head_data),
      .i_head_port  (head_port),
      .o_take       (take_by_egress[m]),
      .o_out_data   (o_out_data[m]),
      .o_out_last   (o_out_last[m]),
      .o_out_valid  (o_out_valid[m]),
      .i_out_ready  (i_out_ready[m])
    );
  end

endmodule

`default_nettype wire

/* xb_egress_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "xb_macros.svh"

module xb_egress_arbiter
  import xb_pkg::*;
#(
  parameter int PORT_INDEX = 0
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire xb_port_mask_t             i_head_valid,
  input  wire xb_port_mask_t             i_head_last,
  input  wire xb_word_t [`XB_NPORTS-1:0] i_head_data,
  input  wire xb_port_t [`XB_NPORTS-1:0] i_head_port,
  output xb_port_mask_t                  o_take,
  output xb_word_t                       o_out_data,
  output logic                           o_out_last,
  output logic                           o_out_valid,
  input  wire                            i_out_ready
);

  xb_arb_state_t state;
  xb_port_t      grant;
  xb_port_t      last_served;
  xb_port_mask_t cand;
  logic          load_en;

  // ----------------------------------------------------------------------
  // Candidates and take
  // ----------------------------------------------------------------------

  // Ingresses whose head packet is addressed to this egress
  always_comb begin
    for (int n = 0; n < `XB_NPORTS; n++) begin
      cand[n] = i_head_valid[n] && (i_head_port[n] == xb_port_t'(PORT_INDEX));
    end
  end

  // Output register loads when empty or being emptied, so a stalled
  // output holds its word and takes nothing from the ingress
  assign load_en = !o_out_valid || i_out_ready;

  // Only the granted ingress is ever taken from
  always_comb begin
    o_take = '0;
    if ((state == ARB_PKT) && load_en) begin
      o_take[grant] = cand[grant];
    end
  end

  // ----------------------------------------------------------------------
  // Grant FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ARB_IDLE;
      grant       <= '0;
      last_served <= '0;
      o_out_valid <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          // Search starts at the ingress after the one served last
          if (|cand) begin
            grant <= xb_rr_next(cand, last_served);
            state <= ARB_PKT;
          end
        end
        ARB_PKT: begin
          // Grant is held until the last word moves into the register
          if ((|o_take) && i_head_last[grant]) begin
            last_served <= grant;
            state       <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
      if (|o_take) begin
        o_out_valid <= 1'b1;
      end else if (i_out_ready) begin
        o_out_valid <= 1'b0;
      end
    end
  end

  // Output word and last flag
  always_ff @(posedge clk) begin
    if (|o_take) begin
      o_out_data <= i_head_data[grant];
      o_out_last <= i_head_last[grant];
    end
  end

endmodule

`default_nettype wire

/* xb_ingress_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "xb_macros.svh"

module xb_ingress_buffer
  import xb_pkg::*;
(
  input  wire                clk,
  input  wire                reset,
  input  wire xb_word_t      i_in_data,
  input  wire                i_in_last,
  input  wire                i_in_valid,
  output logic               o_in_ready,
  output logic               o_lookup_req,
  output xb_epid_t           o_lookup_epid,
  input  wire                i_result_valid,
  input  wire                i_result_hit,
  input  wire xb_port_t      i_result_port,
  output xb_word_t           o_head_data,
  output logic               o_head_last,
  output logic               o_head_valid,
  output xb_port_t           o_head_port,
  input  wire xb_port_mask_t i_egress_take
);

  localparam int BUF_DEPTH = 1 << `XB_BUF_LOG2;
  localparam int DQ_LOG2   = 2;
  localparam int DQ_DEPTH  = 1 << DQ_LOG2;

  // Packet memory with a last flag per word
  xb_word_t                buf_data [BUF_DEPTH];
  logic [BUF_DEPTH-1:0]    buf_last;
  logic [`XB_BUF_LOG2-1:0] wr_ptr;
  logic [`XB_BUF_LOG2-1:0] rd_ptr;
  logic [`XB_BUF_LOG2:0]   word_cnt;
  logic                    in_body;

  // Destination queue, one entry per packet in the buffer
  // Entries are allocated at the header, resolved in order by the table,
  // and freed when the last word of the packet leaves
  xb_epid_t                dq_epid [DQ_DEPTH];
  xb_port_t                dq_port [DQ_DEPTH];
  logic [DQ_LOG2:0]        dq_wr;
  logic [DQ_LOG2:0]        dq_lk;
  logic [DQ_LOG2:0]        dq_rd;
  logic                    dq_full;
  // Complete packets stored, never more than the queue depth
  logic [DQ_LOG2:0]        pkt_cnt;

  logic                    push;
  logic                    hdr_push;
  logic                    pop;
  logic                    pkt_in;
  logic                    pkt_out;

  // ----------------------------------------------------------------------
  // Flow control
  // ----------------------------------------------------------------------

  assign dq_full    = (dq_wr[DQ_LOG2] != dq_rd[DQ_LOG2]) &&
                      (dq_wr[DQ_LOG2-1:0] == dq_rd[DQ_LOG2-1:0]);
  assign o_in_ready = !word_cnt[`XB_BUF_LOG2] && !dq_full;

  assign push     = i_in_valid && o_in_ready;
  assign hdr_push = push && !in_body;
  assign pkt_in   = push && i_in_last;
  // At most one egress takes from this ingress at a time
  assign pop      = |i_egress_take;
  assign pkt_out  = pop && o_head_last;

  // Lookups are issued for the oldest unresolved entry
  assign o_lookup_req  = (dq_lk != dq_wr);
  assign o_lookup_epid = dq_epid[dq_lk[DQ_LOG2-1:0]];

  // ----------------------------------------------------------------------
  // Head of buffer
  // ----------------------------------------------------------------------

  // Packets leave in arrival order, so the head packet is complete whenever
  // any packet is complete. It also needs its destination resolved
  assign o_head_valid = (pkt_cnt != '0) && (dq_lk != dq_rd);
  assign o_head_data  = buf_data[rd_ptr];
  assign o_head_last  = buf_last[rd_ptr];
  assign o_head_port  = dq_port[dq_rd[DQ_LOG2-1:0]];

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      word_cnt <= '0;
      in_body  <= 1'b0;
      dq_wr    <= '0;
      dq_lk    <= '0;
      dq_rd    <= '0;
      pkt_cnt  <= '0;
    end else begin
      if (push) begin
        wr_ptr  <= wr_ptr + 1'b1;
        in_body <= !i_in_last;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   word_cnt <= word_cnt + 1'b1;
        2'b01:   word_cnt <= word_cnt - 1'b1;
        default: word_cnt <= word_cnt;
      endcase
      case ({pkt_in, pkt_out})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
      if (hdr_push) begin
        dq_wr <= dq_wr + 1'b1;
      end
      // The table only answers an outstanding request
      if (i_result_valid) begin
        dq_lk <= dq_lk + 1'b1;
      end
      if (pkt_out) begin
        dq_rd <= dq_rd + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      buf_data[wr_ptr] <= i_in_data;
      buf_last[wr_ptr] <= i_in_last;
    end
    if (hdr_push) begin
      dq_epid[dq_wr[DQ_LOG2-1:0]] <= i_in_data[`XB_EPID_W-1:0];
    end
    // A miss sends the packet to the default egress
    if (i_result_valid) begin
      dq_port[dq_lk[DQ_LOG2-1:0]] <= i_result_hit ? i_result_port
                                                  : xb_port_t'(`XB_DEFAULT_PORT);
    end
  end

endmodule

`default_nettype wire

/* xb_route_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "xb_macros.svh"

module xb_route_table
  import xb_pkg::*;
(
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            i_cfg_stb,
  input  wire xb_epid_t                  i_cfg_epid,
  input  wire xb_port_t                  i_cfg_port,
  output logic                           o_cfg_ack,
  input  wire xb_port_mask_t             i_lookup_req,
  input  wire xb_epid_t [`XB_NPORTS-1:0] i_lookup_epid,
  output xb_port_mask_t                  o_result_valid,
  output xb_port_mask_t                  o_result_hit,
  output xb_port_t                       o_result_port
);

  localparam int TBL_DEPTH = 1 << `XB_TBL_LOG2;

  // Table entries, an ID and a port, qualified by a valid bit
  xb_epid_t                tbl_epid [TBL_DEPTH];
  xb_port_t                tbl_port [TBL_DEPTH];
  logic [TBL_DEPTH-1:0]    tbl_valid;
  // Oldest entry, overwritten by the next write of a new ID
  logic [`XB_TBL_LOG2-1:0] repl_ptr;

  logic                    cfg_hit;
  logic [`XB_TBL_LOG2-1:0] cfg_idx;

  xb_port_mask_t           lk_pending;
  xb_port_t                lk_pick;
  xb_port_t                lk_last;
  xb_epid_t                lk_epid;
  logic                    lk_hit;
  xb_port_t                lk_port;

  // ----------------------------------------------------------------------
  // Configuration write
  // ----------------------------------------------------------------------

  // An ID that is already present is updated in place, so an ID lives in
  // at most one entry and the lookup below never sees two matches
  always_comb begin
    cfg_hit = 1'b0;
    cfg_idx = repl_ptr;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      if (tbl_valid[i] && (tbl_epid[i] == i_cfg_epid)) begin
        cfg_hit = 1'b1;
        cfg_idx = i[`XB_TBL_LOG2-1:0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------------------

  // A requester whose result is on the outputs this cycle still holds its
  // request, so it is left out of the pick for one cycle
  assign lk_pending = i_lookup_req & ~o_result_valid;
  assign lk_pick    = xb_rr_next(lk_pending, lk_last);
  assign lk_epid    = i_lookup_epid[lk_pick];

  // Parallel compare against every entry
  always_comb begin
    lk_hit  = 1'b0;
    lk_port = '0;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      if (tbl_valid[i] && (tbl_epid[i] == lk_epid)) begin
        lk_hit  = 1'b1;
        lk_port = tbl_port[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      tbl_valid      <= '0;
      repl_ptr       <= '0;
      o_cfg_ack      <= 1'b0;
      lk_last        <= '0;
      o_result_valid <= '0;
    end else begin
      // The written entry takes part in lookups from the acknowledge cycle on
      o_cfg_ack <= i_cfg_stb;
      if (i_cfg_stb) begin
        tbl_valid[cfg_idx] <= 1'b1;
        if (!cfg_hit) begin
          repl_ptr <= repl_ptr + 1'b1;
        end
      end
      // At most one result strobe per cycle
      o_result_valid <= '0;
      if (|lk_pending) begin
        o_result_valid[lk_pick] <= 1'b1;
        lk_last                 <= lk_pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_cfg_stb) begin
      tbl_epid[cfg_idx] <= i_cfg_epid;
      tbl_port[cfg_idx] <= i_cfg_port;
    end
    // Port is shared by all requesters, only one valid bit is ever high
    o_result_hit          <= '0;
    o_result_hit[lk_pick] <= lk_hit;
    if (|lk_pending) begin
      o_result_port <= lk_port;
    end
  end

endmodule

`default_nettype wire

/* xb_pkg.sv */
`default_nettype none

`include "xb_macros.svh"

package xb_pkg;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------

  typedef logic [`XB_DATA_W-1:0] xb_word_t;
  typedef logic [`XB_EPID_W-1:0] xb_epid_t;
  typedef logic [`XB_PORT_W-1:0] xb_port_t;

  // One bit per port, bit n belongs to port n
  typedef logic [`XB_NPORTS-1:0] xb_port_mask_t;

  // Egress arbiter FSM, idle or holding a grant for a whole packet
  typedef enum logic {
    ARB_IDLE,
    ARB_PKT
  } xb_arb_state_t;

  // Round-robin pick shared by the table and the egress arbiters
  // The port right after last has the highest priority and last itself the
  // lowest. The index adds wrap modulo the port count
  function automatic xb_port_t xb_rr_next(input xb_port_mask_t req, input xb_port_t last);
    xb_port_t idx;
    xb_rr_next = last;
    for (int i = `XB_NPORTS; i >= 1; i--) begin
      idx = last + i[`XB_PORT_W-1:0];
      if (req[idx]) begin
        xb_rr_next = idx;
      end
    end
  endfunction

endpackage

`default_nettype wire

/* xb_macros.svh */
`ifndef XB_MACROS_SVH
`define XB_MACROS_SVH

// ----------------------------------------------------------------------
// Crossbar geometry
// ----------------------------------------------------------------------

// Number of ingress and egress ports, and the width of a port index
`define XB_NPORTS 4
`define XB_PORT_W 2

// Width of a packet word
`define XB_DATA_W 64

// Endpoint ID width, taken from the low bits of the header word
`define XB_EPID_W 16

// ----------------------------------------------------------------------
// Storage sizes
// ----------------------------------------------------------------------

// Routing table holds 2**XB_TBL_LOG2 entries
`define XB_TBL_LOG2 3

// Ingress buffer holds 2**XB_BUF_LOG2 words, which also caps packet length
`define XB_BUF_LOG2 5

// Egress used when an endpoint ID has no table entry
`define XB_DEFAULT_PORT 0

`endif
